// ==== logic/samplerz_pkg.sv ====
// shared widths and fixed-point formats of the sampler
// base sampler cdt, exp table, sigma constants
// variant and state enums
package samplerz_pkg;

  // ============================================================
  // widths and fixed-point formats
  // ============================================================
  localparam int MU_W    = 32;  // signed q16.16 centre
  localparam int FRAC_W  = 16;  // fraction bits of r and inverse terms
  localparam int Z_W     = 8;   // signed candidate z and base z0
  localparam int W_W     = 16;  // signed sample out
  localparam int CDT_W   = 24;  // base sampler random word
  localparam int CDT_LEN = 18;
  localparam int CCS_W   = 9;   // q1.8 so 256 is 1.0
  localparam int CCS_SHIFT = 23;  // q1.31 product down to q1.8

  // derived datapath widths of the exponent stage
  localparam int D_W   = Z_W + FRAC_W + 1;      // signed z*2^16 - r
  localparam int DSQ_W = 2 * D_W - 1 - FRAC_W;  // (d*d)>>16 kept whole

  // ============================================================
  // base sampler table
  // ============================================================
  // top 24 bits of the falcon reverse cdt
  // tail entries are below 2^48 in the full table so they read as zero here
  localparam logic [CDT_W-1:0] BASE_CDT [CDT_LEN] = '{
    24'd10745844, 24'd5559083, 24'd2260429, 24'd708981,
    24'd169348,   24'd30538,   24'd4132,    24'd417,
    24'd31,       24'd1,       24'd0,       24'd0,
    24'd0,        24'd0,       24'd0,       24'd0,
    24'd0,        24'd0
  };

  // ============================================================
  // sigma constants
  // ============================================================
  localparam logic [FRAC_W-1:0] INV_SIGMA_MAX_SQR_DIV_2 = 16'h269F;  // q0.16 1/(2*1.8205^2)
  localparam logic [FRAC_W-1:0] SIGMA_MIN_512  = 16'hA390;  // q1.15 1.2778
  localparam logic [FRAC_W-1:0] SIGMA_MIN_1024 = 16'hA62E;  // q1.15 1.2983

  // exp(-x) lookup in steps of 1/8
  localparam int EXP_LEN        = 32;
  localparam int EXP_STEP_SHIFT = 13;  // q16.16 step of 0.125
  localparam int EXP_IDX_W      = $clog2(EXP_LEN);

  // round(256*exp(-k/8)) with entry 0 clamped to 255
  localparam logic [7:0] EXP_NEG_TABLE [EXP_LEN] = '{
    8'd255, 8'd226, 8'd199, 8'd176, 8'd155, 8'd137, 8'd121, 8'd107,
    8'd94,  8'd83,  8'd73,  8'd65,  8'd57,  8'd50,  8'd44,  8'd39,
    8'd35,  8'd31,  8'd27,  8'd24,  8'd21,  8'd19,  8'd16,  8'd14,
    8'd13,  8'd11,  8'd10,  8'd9,   8'd8,   8'd7,   8'd6,   8'd5
  };

  typedef enum logic {
    FALCON_512,
    FALCON_1024
  } falcon_type_e;

  typedef enum logic {
    ST_IDLE,
    ST_SAMPLING
  } sampler_state_e;

endpackage

// ==== logic/base_sampler.sv ====
// stage 1 of the sampling pipeline
// cdt compare for z0 and sign combination into z
module base_sampler (
  input  logic                                   clk,
  input  logic                                   rst_n_i,
  input  logic                                   rand_val_i,
  input  logic                                   busy_i,
  input  logic [samplerz_pkg::CDT_W-1:0]         rand_cdt_i,
  input  logic                                   rand_b_i,
  input  logic [7:0]                             rand_8_i,
  output logic                                   val_o,
  output logic signed [samplerz_pkg::Z_W-1:0]    z_o,
  output logic [samplerz_pkg::Z_W-1:0]           z0_o,
  output logic [7:0]                             rand_8_o
);

  logic                           take;    // attempt accepted into pipe
  logic [samplerz_pkg::Z_W-1:0]   z0_cnt;  // entries above rand_cdt
  logic [samplerz_pkg::Z_W-1:0]   z_next;

  assign take = rand_val_i & busy_i;  // random bits outside a job are dropped

  // table is decreasing so this is a thermometer count
  always_comb begin
    z0_cnt = '0;
    for (int i = 0; i < samplerz_pkg::CDT_LEN; i++) begin
      if (samplerz_pkg::BASE_CDT[i] > rand_cdt_i) begin
        z0_cnt = z0_cnt + 1'b1;
      end
    end
  end

  // b=1 gives 1+z0, b=0 gives -z0
  assign z_next = rand_b_i ? (z0_cnt + 1'b1) : ('0 - z0_cnt);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      val_o <= 1'b0;
    end else begin
      val_o <= take;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      z_o      <= z_next;
      z0_o     <= z0_cnt;    // kept for the z0^2 term
      rand_8_o <= rand_8_i;  // consumed in berexp
    end
  end

endmodule

// ==== logic/gaussian_exponent.sv ====
// stages 2 and 3 of the sampling pipeline
// squared distance terms, scaling and clamped exponent x
module gaussian_exponent (
  input  logic                                  clk,
  input  logic                                  rst_n_i,
  input  logic                                  val_i,
  input  logic signed [samplerz_pkg::Z_W-1:0]   z_i,
  input  logic [samplerz_pkg::Z_W-1:0]          z0_i,
  input  logic [7:0]                            rand_8_i,
  input  logic [samplerz_pkg::FRAC_W-1:0]       r_i,
  input  logic [samplerz_pkg::FRAC_W-1:0]       inv_sigma_sqr_div_2_i,
  output logic                                  val_o,
  output logic [samplerz_pkg::MU_W-1:0]         x_o,
  output logic signed [samplerz_pkg::Z_W-1:0]   z_o,
  output logic [7:0]                            rand_8_o
);

  // first stage signals
  logic signed [samplerz_pkg::D_W-1:0]       d;       // z*2^16 - r in q.16
  logic signed [2*samplerz_pkg::D_W-1:0]     d_sq;    // q.32 and never negative
  logic                                      val_s1;
  logic signed [samplerz_pkg::Z_W-1:0]       z_s1;
  logic [7:0]                                r8_s1;
  logic [samplerz_pkg::DSQ_W-1:0]            dsq_s1;  // (d*d)>>16
  logic [2*samplerz_pkg::Z_W-1:0]            z0sq_s1; // integer z0^2

  // second stage signals
  logic [samplerz_pkg::DSQ_W+samplerz_pkg::FRAC_W-1:0] part1_full;
  logic [samplerz_pkg::DSQ_W-1:0]            part1;
  logic [samplerz_pkg::MU_W-1:0]             part2;   // already q16.16
  logic [samplerz_pkg::DSQ_W-1:0]            diff;
  logic [samplerz_pkg::MU_W-1:0]             x_next;

  // ============================================================
  // stage 2a  d^2 and z0^2
  // ============================================================
  assign d = {z_i[samplerz_pkg::Z_W-1], z_i, {samplerz_pkg::FRAC_W{1'b0}}}
           - {{(samplerz_pkg::Z_W+1){1'b0}}, r_i};
  assign d_sq = d * d;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      val_s1 <= 1'b0;
    end else begin
      val_s1 <= val_i;
    end
  end

  always_ff @(posedge clk) begin
    dsq_s1  <= d_sq[2*samplerz_pkg::D_W-2:samplerz_pkg::FRAC_W];  // sign bit dropped, q.16 again
    z0sq_s1 <= z0_i * z0_i;
    z_s1    <= z_i;
    r8_s1   <= rand_8_i;
  end

  // ============================================================
  // stage 2b  scale, subtract, clamp
  // ============================================================
  assign part1_full = dsq_s1 * inv_sigma_sqr_div_2_i;
  assign part1      = part1_full[samplerz_pkg::DSQ_W+samplerz_pkg::FRAC_W-1:samplerz_pkg::FRAC_W];
  assign part2      = z0sq_s1 * samplerz_pkg::INV_SIGMA_MAX_SQR_DIV_2;

  always_comb begin
    if (part1 > {1'b0, part2}) begin
      diff = part1 - {1'b0, part2};
    end else begin
      diff = '0;  // negative x clamps to 0
    end
  end

  // bit 32 set saturates far beyond the exp table
  assign x_next = diff[samplerz_pkg::DSQ_W-1] ? '1 : diff[samplerz_pkg::MU_W-1:0];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      val_o <= 1'b0;
    end else begin
      val_o <= val_s1;
    end
  end

  always_ff @(posedge clk) begin
    x_o      <= x_next;
    z_o      <= z_s1;
    rand_8_o <= r8_s1;
  end

endmodule

// ==== logic/berexp.sv ====
// stage 4 of the sampling pipeline
// exp table lookup, ccs scaling and bernoulli accept compare
module berexp (
  input  logic                                  clk,
  input  logic                                  rst_n_i,
  input  logic                                  val_i,
  input  logic [samplerz_pkg::MU_W-1:0]         x_i,
  input  logic signed [samplerz_pkg::Z_W-1:0]   z_i,
  input  logic [7:0]                            rand_8_i,
  input  logic [samplerz_pkg::CCS_W-1:0]        ccs_i,
  output logic                                  val_o,
  output logic                                  accept_o,
  output logic signed [samplerz_pkg::Z_W-1:0]   z_o
);

  localparam int IDX_LO = samplerz_pkg::EXP_STEP_SHIFT;
  localparam int IDX_HI = samplerz_pkg::EXP_STEP_SHIFT + samplerz_pkg::EXP_IDX_W - 1;

  logic                                     past_table;  // k >= EXP_LEN
  logic [7:0]                               exp_val;     // q0.8 exp(-x)
  logic [8+samplerz_pkg::CCS_W-1:0]         prod;
  logic [samplerz_pkg::CCS_W-1:0]           threshold;

  assign past_table = |x_i[samplerz_pkg::MU_W-1:IDX_HI+1];
  assign exp_val    = past_table ? 8'd0 : samplerz_pkg::EXP_NEG_TABLE[x_i[IDX_HI:IDX_LO]];

  // ccs*exp(-x) back to q0.8 with max 255
  assign prod      = exp_val * ccs_i;
  assign threshold = prod[8+samplerz_pkg::CCS_W-1:8];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      val_o <= 1'b0;
    end else begin
      val_o <= val_i;
    end
  end

  always_ff @(posedge clk) begin
    accept_o <= ({1'b0, rand_8_i} < threshold);  // p(accept) = threshold/256
    z_o      <= z_i;
  end

endmodule

// ==== logic/job_ctrl.sv ====
// job register and per-job preparation of floor(mu), r and ccs
// sampling state and registered outcome
module job_ctrl (
  input  logic                                  clk,
  input  logic                                  rst_n_i,
  input  logic                                  start_i,
  input  logic [samplerz_pkg::MU_W-1:0]         mu_i,
  input  logic [samplerz_pkg::FRAC_W-1:0]       inv_sigma_prime_i,
  input  logic [samplerz_pkg::FRAC_W-1:0]       inv_sigma_sqr_div_2_i,
  input  samplerz_pkg::falcon_type_e            falcon_type_i,
  input  logic                                  attempt_val_i,
  input  logic                                  accept_i,
  input  logic signed [samplerz_pkg::Z_W-1:0]   z_i,
  output logic                                  busy_o,
  output logic signed [samplerz_pkg::W_W-1:0]   floor_mu_o,
  output logic [samplerz_pkg::FRAC_W-1:0]       r_o,
  output logic [samplerz_pkg::CCS_W-1:0]        ccs_o,
  output logic [samplerz_pkg::FRAC_W-1:0]       inv_sigma_sqr_div_2_o,
  output logic                                  dout_val_o,
  output logic signed [samplerz_pkg::W_W-1:0]   w_o,
  output logic                                  request_rand_o
);

  samplerz_pkg::sampler_state_e           state;
  logic [samplerz_pkg::FRAC_W-1:0]        sigma_min;  // q1.15
  logic [2*samplerz_pkg::FRAC_W-1:0]      ccs_prod;   // q1.31
  logic [samplerz_pkg::CCS_W-1:0]         ccs_raw;
  logic [samplerz_pkg::CCS_W-1:0]         ccs_next;
  logic                                   take_job;
  logic                                   hit;        // accepted attempt of this job
  logic                                   miss;       // rejected attempt of this job

  // ============================================================
  // ccs = sigma_min * inv_sigma_prime
  // ============================================================
  assign sigma_min = (falcon_type_i == samplerz_pkg::FALCON_1024) ?
                     samplerz_pkg::SIGMA_MIN_1024 : samplerz_pkg::SIGMA_MIN_512;
  assign ccs_prod  = sigma_min * inv_sigma_prime_i;
  assign ccs_raw   = ccs_prod[samplerz_pkg::CCS_SHIFT+samplerz_pkg::CCS_W-1:samplerz_pkg::CCS_SHIFT];
  assign ccs_next  = (ccs_raw > 9'd256) ? 9'd256 : ccs_raw;  // cap at 1.0

  assign busy_o   = (state == samplerz_pkg::ST_SAMPLING);
  assign take_job = start_i & (state == samplerz_pkg::ST_IDLE);
  assign hit      = busy_o & attempt_val_i & accept_i;
  assign miss     = busy_o & attempt_val_i & ~accept_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state <= samplerz_pkg::ST_IDLE;
    end else begin
      case (state)
        samplerz_pkg::ST_IDLE: begin
          if (start_i) state <= samplerz_pkg::ST_SAMPLING;
        end
        samplerz_pkg::ST_SAMPLING: begin
          if (hit) state <= samplerz_pkg::ST_IDLE;  // first accept ends the job
        end
        default: state <= samplerz_pkg::ST_IDLE;
      endcase
    end
  end

  // job terms, stable for the whole job
  always_ff @(posedge clk) begin
    if (take_job) begin
      floor_mu_o            <= mu_i[samplerz_pkg::MU_W-1:samplerz_pkg::FRAC_W];  // mu >>> 16
      r_o                   <= mu_i[samplerz_pkg::FRAC_W-1:0];
      ccs_o                 <= ccs_next;
      inv_sigma_sqr_div_2_o <= inv_sigma_sqr_div_2_i;
    end
  end

  // ============================================================
  // outcome
  // ============================================================
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      dout_val_o     <= 1'b0;
      request_rand_o <= 1'b0;
    end else begin
      dout_val_o     <= hit;
      request_rand_o <= miss;  // ask for a fresh random triple
    end
  end

  always_ff @(posedge clk) begin
    if (hit) begin
      w_o <= floor_mu_o + {{(samplerz_pkg::W_W-samplerz_pkg::Z_W){z_i[samplerz_pkg::Z_W-1]}}, z_i};
    end
  end

endmodule

// ==== logic/samplerz_top.sv ====
// top level of the discrete gaussian sampler
// job controller and the four pipeline stages
module samplerz_top (
  input  logic                                  clk,
  input  logic                                  rst_n_i,
  input  logic                                  start_i,
  input  logic [samplerz_pkg::MU_W-1:0]         mu_i,
  input  logic [samplerz_pkg::FRAC_W-1:0]       inv_sigma_prime_i,
  input  logic [samplerz_pkg::FRAC_W-1:0]       inv_sigma_sqr_div_2_i,
  input  samplerz_pkg::falcon_type_e            falcon_type_i,
  input  logic                                  rand_val_i,
  input  logic [samplerz_pkg::CDT_W-1:0]        rand_cdt_i,
  input  logic                                  rand_b_i,
  input  logic [7:0]                            rand_8_i,
  output logic                                  dout_val_o,
  output logic signed [samplerz_pkg::W_W-1:0]   w_o,
  output logic                                  request_rand_o,
  output logic                                  busy_o
);

  // job terms
  logic [samplerz_pkg::FRAC_W-1:0]        r;
  logic [samplerz_pkg::CCS_W-1:0]         ccs;
  logic [samplerz_pkg::FRAC_W-1:0]        inv_sq;

  // stage 1 to 2
  logic                                   bs_val;
  logic signed [samplerz_pkg::Z_W-1:0]    bs_z;
  logic [samplerz_pkg::Z_W-1:0]           bs_z0;
  logic [7:0]                             bs_r8;

  // stage 3 to 4
  logic                                   ge_val;
  logic [samplerz_pkg::MU_W-1:0]          ge_x;
  logic signed [samplerz_pkg::Z_W-1:0]    ge_z;
  logic [7:0]                             ge_r8;

  // stage 4 to controller
  logic                                   be_val;
  logic                                   be_accept;
  logic signed [samplerz_pkg::Z_W-1:0]    be_z;

  job_ctrl i_job_ctrl (
    .clk                   (clk),
    .rst_n_i               (rst_n_i),
    .start_i               (start_i),
    .mu_i                  (mu_i),
    .inv_sigma_prime_i     (inv_sigma_prime_i),
    .inv_sigma_sqr_div_2_i (inv_sigma_sqr_div_2_i),
    .falcon_type_i         (falcon_type_i),
    .attempt_val_i         (be_val),
    .accept_i              (be_accept),
    .z_i                   (be_z),
    .busy_o                (busy_o),
    .floor_mu_o            (),        // w is formed inside the controller
    .r_o                   (r),
    .ccs_o                 (ccs),
    .inv_sigma_sqr_div_2_o (inv_sq),
    .dout_val_o            (dout_val_o),
    .w_o                   (w_o),
    .request_rand_o        (request_rand_o)
  );

  base_sampler i_base_sampler (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .rand_val_i (rand_val_i),
    .busy_i     (busy_o),
    .rand_cdt_i (rand_cdt_i),
    .rand_b_i   (rand_b_i),
    .rand_8_i   (rand_8_i),
    .val_o      (bs_val),
    .z_o        (bs_z),
    .z0_o       (bs_z0),
    .rand_8_o   (bs_r8)
  );

  gaussian_exponent i_gaussian_exponent (
    .clk                   (clk),
    .rst_n_i               (rst_n_i),
    .val_i                 (bs_val),
    .z_i                   (bs_z),
    .z0_i                  (bs_z0),
    .rand_8_i              (bs_r8),
    .r_i                   (r),
    .inv_sigma_sqr_div_2_i (inv_sq),
    .val_o                 (ge_val),
    .x_o                   (ge_x),
    .z_o                   (ge_z),
    .rand_8_o              (ge_r8)
  );

  berexp i_berexp (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .val_i    (ge_val),
    .x_i      (ge_x),
    .z_i      (ge_z),
    .rand_8_i (ge_r8),
    .ccs_i    (ccs),
    .val_o    (be_val),
    .accept_o (be_accept),
    .z_o      (be_z)
  );

endmodule

// ==== verif/samplerz_tb.sv ====
// testbench for the discrete gaussian sampler
// stimulus table of jobs and random triples, fixed-point reference model
// cycle-exact output schedule, timeout
module samplerz_tb;

  localparam int SEED     = 47326;
  localparam int HALF_PER = 20;  // 40 unit clock period
  localparam int MAX_ROWS = 24;
  localparam int MAX_ATT  = 8;
  localparam int N_RAND   = 12;  // random jobs after the directed ones
  localparam int LATENCY  = 5;   // rand_val_i to dout_val_o / request_rand_o
  localparam logic [7:0] VAR_R8 = 8'd246;  // between the two variant thresholds

  logic                               clk;
  logic                               rst_n_i;
  logic                               start_i;
  logic [31:0]                        mu_i;
  logic [15:0]                        inv_sigma_prime_i;
  logic [15:0]                        inv_sigma_sqr_div_2_i;
  samplerz_pkg::falcon_type_e         falcon_type_i;
  logic                               rand_val_i;
  logic [23:0]                        rand_cdt_i;
  logic                               rand_b_i;
  logic [7:0]                         rand_8_i;
  logic                               dout_val_o;
  logic signed [15:0]                 w_o;
  logic                               request_rand_o;
  logic                               busy_o;

  // ============================================================
  // stimulus table with one row per job
  // ============================================================
  logic [31:0]                        row_mu  [MAX_ROWS];
  logic [15:0]                        row_isp [MAX_ROWS];
  logic [15:0]                        row_isq [MAX_ROWS];
  samplerz_pkg::falcon_type_e         row_ft  [MAX_ROWS];
  int                                 row_n   [MAX_ROWS];  // triples in the row
  logic [23:0]                        t_cdt   [MAX_ROWS][MAX_ATT];
  logic                               t_b     [MAX_ROWS][MAX_ATT];
  logic [7:0]                         t_r8    [MAX_ROWS][MAX_ATT];
  int                                 n_rows = 0;

  // expected outputs keyed by cycle number
  bit                                 exp_req  [int];
  bit                                 exp_dout [int];
  logic [15:0]                        exp_w    [int];

  int                                 cyc = 0;
  int                                 cycle_limit = 1000;
  bit                                 any_started = 1'b0;
  int unsigned                        seed_val;

  samplerz_top i_samplerz_top (
    .clk                   (clk),
    .rst_n_i               (rst_n_i),
    .start_i               (start_i),
    .mu_i                  (mu_i),
    .inv_sigma_prime_i     (inv_sigma_prime_i),
    .inv_sigma_sqr_div_2_i (inv_sigma_sqr_div_2_i),
    .falcon_type_i         (falcon_type_i),
    .rand_val_i            (rand_val_i),
    .rand_cdt_i            (rand_cdt_i),
    .rand_b_i              (rand_b_i),
    .rand_8_i              (rand_8_i),
    .dout_val_o            (dout_val_o),
    .w_o                   (w_o),
    .request_rand_o        (request_rand_o),
    .busy_o                (busy_o)
  );

  always #HALF_PER clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  task automatic abort_run;
    $display("Test failed");
    $fatal(1);
  endtask

  // inputs change a little after the rising edge
  task automatic step;
    @(posedge clk);
    #2;
  endtask

  task automatic add_job(input logic [31:0] mu, input logic [15:0] isp,
                         input logic [15:0] isq, input samplerz_pkg::falcon_type_e ft);
    row_mu[n_rows]  = mu;
    row_isp[n_rows] = isp;
    row_isq[n_rows] = isq;
    row_ft[n_rows]  = ft;
    row_n[n_rows]   = 0;
    n_rows          = n_rows + 1;
  endtask

  task automatic add_triple(input logic [23:0] cdt, input logic b, input logic [7:0] r8);
    t_cdt[n_rows-1][row_n[n_rows-1]] = cdt;
    t_b[n_rows-1][row_n[n_rows-1]]   = b;
    t_r8[n_rows-1][row_n[n_rows-1]]  = r8;
    row_n[n_rows-1]                  = row_n[n_rows-1] + 1;
  endtask

  // ============================================================
  // reference model of one attempt in plain integer arithmetic
  // ============================================================
  function automatic void model_attempt(
    input  logic [31:0]                mu,
    input  logic [15:0]                isp,
    input  logic [15:0]                isq,
    input  samplerz_pkg::falcon_type_e ft,
    input  logic [23:0]                cdt,
    input  logic                       b,
    input  logic [7:0]                 r8,
    output bit                         acc,
    output logic [15:0]                w,
    output longint                     thr
  );
    longint r, floor_mu, sm, ccs, z0, z, d, dsq, part1, part2, x, k, ev;
    r        = longint'(mu[15:0]);
    floor_mu = (longint'($signed(mu)) - r) / 65536;  // exact division
    if (ft == samplerz_pkg::FALCON_1024) sm = longint'(samplerz_pkg::SIGMA_MIN_1024);
    else sm = longint'(samplerz_pkg::SIGMA_MIN_512);
    ccs = (sm * longint'(isp)) / 8388608;  // q1.15 * q0.16 down to q1.8
    if (ccs > 256) ccs = 256;
    z0 = 0;
    for (int i = 0; i < samplerz_pkg::CDT_LEN; i++) begin
      if (samplerz_pkg::BASE_CDT[i] > cdt) z0 = z0 + 1;
    end
    z     = b ? (z0 + 1) : -z0;
    d     = z * 65536 - r;
    dsq   = (d * d) / 65536;
    part1 = (dsq * longint'(isq)) / 65536;
    part2 = z0 * z0 * longint'(samplerz_pkg::INV_SIGMA_MAX_SQR_DIV_2);
    x     = part1 - part2;
    if (x < 0) x = 0;
    k = x / 8192;  // steps of 1/8
    if (k < samplerz_pkg::EXP_LEN) ev = longint'(samplerz_pkg::EXP_NEG_TABLE[int'(k)]);
    else ev = 0;
    thr = (ev * ccs) / 256;
    acc = (longint'(r8) < thr);
    w   = 16'(floor_mu + z);
  endfunction

  // one job with start, back to back triples, wait for the end and drain
  task automatic run_row(input int j);
    bit          acc;
    bit          done;
    logic [15:0] w;
    longint      thr;
    step;
    start_i               = 1'b1;
    mu_i                  = row_mu[j];
    inv_sigma_prime_i     = row_isp[j];
    inv_sigma_sqr_div_2_i = row_isq[j];
    falcon_type_i         = row_ft[j];
    any_started           = 1'b1;
    step;
    start_i = 1'b0;
    assert (busy_o == 1'b1) else begin
      $display("FAIL busy_o got %h expected %h at cycle %0d", busy_o, 1'b1, cyc);
      abort_run();
    end
    done = 1'b0;
    for (int i = 0; i < row_n[j]; i++) begin
      if (i > 0) step;
      rand_val_i = 1'b1;
      rand_cdt_i = t_cdt[j][i];
      rand_b_i   = t_b[j][i];
      rand_8_i   = t_r8[j][i];
      model_attempt(row_mu[j], row_isp[j], row_isq[j], row_ft[j],
                    t_cdt[j][i], t_b[j][i], t_r8[j][i], acc, w, thr);
      if (!done) begin  // nothing expected after the first accept
        if (acc) begin
          exp_dout[cyc+LATENCY] = 1'b1;
          exp_w[cyc+LATENCY]    = w;
          done                  = 1'b1;
        end else begin
          exp_req[cyc+LATENCY] = 1'b1;
        end
      end
    end
    step;
    rand_val_i = 1'b0;
    assert (done) else begin
      $display("stimulus row %0d has no attempt that the model accepts", j);
      abort_run();
    end
    while (busy_o) step;
    repeat (6) step;  // pipeline drains before the next job
  endtask

  // ============================================================
  // output checks sampled mid-cycle
  // ============================================================
  always @(negedge clk) begin : check_outputs
    bit want_req;
    bit want_dout;
    if (rst_n_i) begin
      want_req  = exp_req.exists(cyc);
      want_dout = exp_dout.exists(cyc);
      assert (request_rand_o == want_req) else begin
        $display("FAIL request_rand_o got %h expected %h at cycle %0d",
                 request_rand_o, want_req, cyc);
        abort_run();
      end
      assert (dout_val_o == want_dout) else begin
        $display("FAIL dout_val_o got %h expected %h at cycle %0d", dout_val_o, want_dout, cyc);
        abort_run();
      end
      if (want_dout) begin
        assert (w_o == exp_w[cyc]) else begin
          $display("FAIL w_o got %h expected %h at cycle %0d", w_o, exp_w[cyc], cyc);
          abort_run();
        end
        assert (busy_o == 1'b0) else begin  // busy drops with the result
          $display("FAIL busy_o got %h expected %h at cycle %0d", busy_o, 1'b0, cyc);
          abort_run();
        end
      end
      if (!any_started) begin
        assert (busy_o == 1'b0) else begin
          $display("FAIL busy_o got %h expected %h at cycle %0d", busy_o, 1'b0, cyc);
          abort_run();
        end
      end
    end
  end

  always @(posedge clk) begin
    assert (cyc <= cycle_limit) else begin
      $display("timeout, the run did not finish within %0d cycles", cycle_limit);
      abort_run();
    end
  end

  // ============================================================
  // table build and main sequence
  // ============================================================
  initial begin : main
    bit          acc;
    logic [15:0] w;
    longint      thr_a;
    longint      thr_b;
    int          n_att;
    clk                   = 1'b0;
    rst_n_i               = 1'b0;
    start_i               = 1'b0;
    mu_i                  = '0;
    inv_sigma_prime_i     = '0;
    inv_sigma_sqr_div_2_i = '0;
    falcon_type_i         = samplerz_pkg::FALCON_512;
    rand_val_i            = 1'b0;
    rand_cdt_i            = '0;
    rand_b_i              = 1'b0;
    rand_8_i              = '0;
    seed_val              = $urandom(SEED);

    // accepted first try with positive mu and b=1, negative mu and b=0
    add_job(32'h0003_4000, 16'hC000, 16'h4000, samplerz_pkg::FALCON_512);
    add_triple(24'd3000000, 1'b1, 8'd0);
    add_job(32'hFFFD_8000, 16'hC000, 16'h4000, samplerz_pkg::FALCON_1024);
    add_triple(24'd6000000, 1'b0, 8'd0);
    // rejected by rand_8
    add_job(32'h0001_0000, 16'hC000, 16'h4000, samplerz_pkg::FALCON_512);
    add_triple(24'hFFFFFF, 1'b0, 8'd255);
    add_triple(24'hFFFFFF, 1'b1, 8'd0);
    // rejected by large x with threshold 0
    add_job(32'h0000_0000, 16'hC000, 16'hFFFF, samplerz_pkg::FALCON_512);
    add_triple(24'd0, 1'b1, 8'd0);
    add_triple(24'hFFFFFF, 1'b0, 8'd0);
    // several in flight with the accept at index 3 and a silent tail
    add_job(32'hFFF9_0000, 16'hC000, 16'h4000, samplerz_pkg::FALCON_1024);
    add_triple(24'hFFFFFF, 1'b0, 8'd255);
    add_triple(24'd0, 1'b1, 8'd0);
    add_triple(24'hFFFFFF, 1'b1, 8'd255);
    add_triple(24'hFFFFFF, 1'b0, 8'd0);
    add_triple(24'hFFFFFF, 1'b1, 8'd0);
    add_triple(24'd100, 1'b0, 8'd0);
    // same job under both variants
    for (int v = 0; v < 2; v++) begin
      add_job(32'h0005_0000, 16'hC000, 16'h4000,
              (v == 0) ? samplerz_pkg::FALCON_512 : samplerz_pkg::FALCON_1024);
      add_triple(24'hFFFFFF, 1'b0, VAR_R8);
      add_triple(24'hFFFFFF, 1'b0, 8'd0);
    end
    model_attempt(32'h0005_0000, 16'hC000, 16'h4000, samplerz_pkg::FALCON_512,
                  24'hFFFFFF, 1'b0, VAR_R8, acc, w, thr_a);
    model_attempt(32'h0005_0000, 16'hC000, 16'h4000, samplerz_pkg::FALCON_1024,
                  24'hFFFFFF, 1'b0, VAR_R8, acc, w, thr_b);
    assert ((thr_a <= longint'(VAR_R8)) && (longint'(VAR_R8) < thr_b)) else begin
      $display("variant rand_8 does not sit between the two variant thresholds");
      abort_run();
    end

    // random jobs with mu in +-64, last triple z=0 with rand_8=0 always accepts
    for (int j = 0; j < N_RAND; j++) begin
      add_job(32'($urandom_range(32'h0080_0000)) - 32'h0040_0000,
              16'h8000 | 16'($urandom), 16'($urandom),
              samplerz_pkg::falcon_type_e'(1'($urandom)));
      n_att = int'($urandom_range(4, 1));
      for (int i = 0; i < n_att; i++) begin
        add_triple(24'($urandom), 1'($urandom), 8'($urandom));
      end
      add_triple(24'hFFFFFF, 1'b0, 8'd0);
    end

    // per row the start, attempts, latency and drain
    cycle_limit = 50;
    for (int j = 0; j < n_rows; j++) cycle_limit = cycle_limit + row_n[j] + 12;

    step;
    step;
    step;
    rst_n_i = 1'b1;
    repeat (2) step;  // idle outputs after reset

    for (int j = 0; j < n_rows; j++) run_row(j);

    $display("Test passed");
    $finish;
  end

endmodule

// ==== list.f ====
logic/samplerz_pkg.sv
logic/base_sampler.sv
logic/gaussian_exponent.sv
logic/berexp.sv
logic/job_ctrl.sv
logic/samplerz_top.sv
verif/samplerz_tb.sv

// ==== Makefile ====
# Verilator build and run of the sampler testbench

TOP := samplerz_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
